/* crack_settings.svh */
`ifndef CRACK_SETTINGS_SVH
`define CRACK_SETTINGS_SVH

// Number of hashing units behind the dispatcher
`define N_UNITS 4

// Width of one unit output item, 8 or 16
`define UNIT_OUTPUT_WIDTH 8

// Sixteen-bit words in one result (IDs plus digest)
`define RESULT_WORDS 36

// Comparator table index width and depth
`define HASH_NUM_W 3
`define CMP_DEPTH 8

`endif

/* crack_pkg.sv */
package crack_pkg;

	// One candidate job from the host
	typedef struct packed {
		logic [31:0] key;
		logic [15:0] word_id;
	} job_t;

	// Result IDs, word 0 sits in the low bits
	typedef struct packed {
		logic [15:0] key_hi;
		logic [15:0] key_lo;
		logic [15:0] pkt_id;
		logic [15:0] word_id;
	} unit_ids_t;

	// Output packet kinds seen by the host
	typedef enum logic [1:0] {
		RESULT = 2'd0,
		CMP_RESULT = 2'd1,
		PACKET_DONE = 2'd2
	} outpkt_type_e;

endpackage

/* job_dispatcher.sv */
`timescale 1ns/1ps
`include "crack_settings.svh"

module job_dispatcher (
	input  logic CLK,
	input  logic rst_n,
	input  logic pkt_start,
	input  logic [15:0] pkt_id_in,
	input  logic [31:0] pkt_len,
	input  logic job_wr,
	input  crack_pkg::job_t job,
	input  logic [`N_UNITS-1:0] unit_busy,
	input  logic pkt_rx_done,
	output logic job_full,
	output logic [`N_UNITS-1:0] unit_start,
	output crack_pkg::job_t unit_job,
	output logic [15:0] unit_pkt_id,
	output logic [31:0] num_processed_tx,
	output logic [15:0] pkt_id_tx,
	output logic pkt_tx_done
);
	logic [5:0] delay_cnt;
	logic ready;
	logic pkt_open;
	logic [31:0] pkt_len_r;
	logic [`N_UNITS-1:0] unit_taken;
	logic [`N_UNITS-1:0] pick;
	logic job_accept;

	// A unit started this cycle shows busy only on the next edge
	assign unit_taken = unit_busy | unit_start;

	// Lowest zero bit of unit_taken, all zeros when every unit is taken
	assign pick = ~unit_taken & (unit_taken + 1'b1);

	assign job_full = !ready || (&unit_taken);
	assign job_accept = job_wr && !job_full;
	assign pkt_tx_done = pkt_open && (num_processed_tx == pkt_len_r);

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			delay_cnt <= '0;
			ready <= 1'b0;
			pkt_open <= 1'b0;
			pkt_len_r <= '0;
			pkt_id_tx <= '0;
			num_processed_tx <= '0;
			unit_start <= '0;
		end else begin
			unit_start <= '0;

			// Same start-up delay as the collector
			if (!ready) begin
				delay_cnt <= delay_cnt + 1'b1;
				if (delay_cnt == 6'd63)
					ready <= 1'b1;
			end

			// New packet once the previous one is fully collected
			if (pkt_start && (!pkt_open || pkt_rx_done)) begin
				pkt_open <= 1'b1;
				pkt_id_tx <= pkt_id_in;
				pkt_len_r <= pkt_len;
				num_processed_tx <= '0;
			end else if (pkt_rx_done) begin
				pkt_open <= 1'b0;
				num_processed_tx <= '0;
			end

			if (job_accept) begin
				unit_start <= pick;
				num_processed_tx <= num_processed_tx + 1'b1;
			end
		end
	end

	// Job bus shared by all units, qualified by unit_start
	always_ff @(posedge CLK) begin
		if (job_accept) begin
			unit_job <= job;
			unit_pkt_id <= pkt_id_tx;
		end
	end

	a_no_wr_when_full: assert property (
		@(posedge CLK) disable iff (!rst_n)
		job_wr |-> !job_full
	);

endmodule

/* hash_unit.sv */
`timescale 1ns/1ps
`include "crack_settings.svh"

module hash_unit (
	input  logic CLK,
	input  logic rst_n,
	input  logic start,
	input  crack_pkg::job_t job,
	input  logic [15:0] pkt_id,
	input  logic rd_en,
	output logic busy,
	output logic [`UNIT_OUTPUT_WIDTH-1:0] dout,
	output logic empty
);
	localparam int W = `UNIT_OUTPUT_WIDTH;
	localparam int FRAME_BITS = `RESULT_WORDS * 16;
	localparam int LAST_ITEM = FRAME_BITS / W + 1;
	localparam logic [63:0] MIX_CONST = 64'h9E37_79B9_7F4A_7C15;

	typedef enum logic [1:0] {
		S_IDLE,
		S_MIX,
		S_OUT
	} state_e;

	state_e state;
	logic [3:0] step;
	logic [6:0] item;
	logic [63:0] x;
	logic [63:0] x_next;
	logic [31:0] key_r;
	logic [FRAME_BITS-1:0] frame_sr;
	crack_pkg::unit_ids_t ids;

	always_comb begin
		ids.word_id = job.word_id;
		ids.pkt_id = pkt_id;
		ids.key_lo = job.key[15:0];
		ids.key_hi = job.key[31:16];
	end

	// One mixing step: rotate left 13, XOR constant, add key
	assign x_next = ({x[50:0], x[63:51]} ^ MIX_CONST) + {32'h0, key_r};

	// Item 0 is the header, the last item the terminator
	assign dout = (item == 7'd0) ? {W{1'b1}}
		: (item == 7'(LAST_ITEM)) ? {W{1'b0}}
		: frame_sr[W-1:0];

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			state <= S_IDLE;
			step <= '0;
			item <= '0;
			busy <= 1'b0;
			empty <= 1'b1;
		end else begin
			case (state)
				S_IDLE: begin
					if (start) begin
						state <= S_MIX;
						step <= '0;
						busy <= 1'b1;
					end
				end

				// Steps 0 to 7 mix, step 8 publishes the frame
				S_MIX: begin
					if (step == 4'd8) begin
						state <= S_OUT;
						item <= '0;
						empty <= 1'b0;
					end else begin
						step <= step + 1'b1;
					end
				end

				S_OUT: begin
					if (rd_en) begin
						if (item == 7'(LAST_ITEM)) begin
							state <= S_IDLE;
							busy <= 1'b0;
							empty <= 1'b1;
						end else begin
							item <= item + 1'b1;
						end
					end
				end

				default: state <= S_IDLE;
			endcase
		end
	end

	// IDs enter at the top and get pushed down by each digest word
	always_ff @(posedge CLK) begin
		if (state == S_IDLE && start) begin
			x <= {job.key, 16'h0, job.word_id};
			key_r <= job.key;
			frame_sr[FRAME_BITS-1 -: 64] <= ids;
		end else if (state == S_MIX && step != 4'd8) begin
			x <= x_next;
			frame_sr <= {x_next, frame_sr[FRAME_BITS-1:64]};
		end else if (state == S_OUT && rd_en && item != 7'd0) begin
			frame_sr <= frame_sr >> W;
		end
	end

	a_no_start_busy: assert property (
		@(posedge CLK) disable iff (!rst_n)
		start |-> !busy
	);

	// Collector only reads frames that are complete
	a_rd_not_empty: assert property (
		@(posedge CLK) disable iff (!rst_n)
		rd_en |-> !empty
	);

endmodule

/* result_collector.sv */
`timescale 1ns/1ps
`include "crack_settings.svh"

module result_collector (
	input  logic CLK,
	input  logic rst_n,
	input  logic mode_cmp,
	input  logic [`N_UNITS*`UNIT_OUTPUT_WIDTH-1:0] unit_dout,
	input  logic [`N_UNITS-1:0] unit_empty,
	output logic [`N_UNITS-1:0] unit_rd_en,
	input  logic [31:0] num_processed_tx,
	input  logic [15:0] pkt_id_tx,
	input  logic pkt_tx_done,
	output logic pkt_rx_done,
	output logic [31:0] cmp_data,
	output logic cmp_start,
	input  logic cmp_found,
	input  logic cmp_finished,
	input  logic [`HASH_NUM_W-1:0] cmp_hash_num,
	output crack_pkg::outpkt_type_e outpkt_type,
	output logic [15:0] dout,
	input  logic [5:0] rd_addr,
	output logic [15:0] pkt_id,
	output logic [31:0] num_processed,
	output logic [`HASH_NUM_W-1:0] hash_num,
	input  logic rd_en,
	output logic empty,
	output logic [1:0] err
);
	localparam int W = `UNIT_OUTPUT_WIDTH;
	localparam int ITEMS_PER_WORD = 16 / W;
	localparam int FRAME_ITEMS = `RESULT_WORDS * ITEMS_PER_WORD + 2;
	localparam int UNIT_W = (`N_UNITS > 1) ? $clog2(`N_UNITS) : 1;

	typedef enum logic [3:0] {
		ST_DELAY,
		ST_WAIT,
		ST_RX_HEADER,
		ST_RX_DATA,
		ST_RX_END,
		ST_CMP,
		ST_OUT_RESULT,
		ST_PKT_ACCOUNT,
		ST_OUT_DONE,
		ST_HALT
	} state_e;

	state_e state;
	logic [5:0] delay_cnt;
	logic [UNIT_W-1:0] unit_num;
	logic [UNIT_W-1:0] unit_next;
	logic [6:0] rd_left;
	logic [W-1:0] din;
	logic din_vld;
	logic [1:0] rd_count;
	logic [15:0] rd_tmp;
	logic [15:0] word_next;
	logic word_done;
	logic [5:0] word_cnt;
	logic cmp_done;
	logic cmp_hit;
	logic [`HASH_NUM_W-1:0] hit_num;
	logic [15:0] out_buf [64];

	assign unit_next = (unit_num == UNIT_W'(`N_UNITS - 1)) ? '0 : unit_num + 1'b1;

	// Whole frame is ready once empty drops, so read it back to back
	assign unit_rd_en = (rd_left != 7'd0) ? (`N_UNITS'(1) << unit_num) : '0;

	assign dout = out_buf[rd_addr];

	// Insert the incoming item into the word being built, low part first
	always_comb begin
		word_next = rd_tmp;
		word_next[rd_count*W +: W] = din;
	end

	assign word_done = (state == ST_RX_DATA) && din_vld
		&& (rd_count == ITEMS_PER_WORD - 1);

	always_ff @(posedge CLK) begin
		din <= unit_dout[unit_num*W +: W];
		if (state == ST_RX_DATA && din_vld)
			rd_tmp <= word_next;
		if (word_done)
			out_buf[word_cnt] <= word_next;
		// Low half of digest word 0 lives in result words 4 and 5
		if (word_done && word_cnt == 6'd4)
			cmp_data[15:0] <= word_next;
		if (word_done && word_cnt == 6'd5)
			cmp_data[31:16] <= word_next;
	end

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			state <= ST_DELAY;
			delay_cnt <= '0;
			unit_num <= '0;
			rd_left <= '0;
			din_vld <= 1'b0;
			rd_count <= '0;
			word_cnt <= '0;
			cmp_start <= 1'b0;
			cmp_done <= 1'b0;
			cmp_hit <= 1'b0;
			hit_num <= '0;
			hash_num <= '0;
			pkt_id <= '0;
			pkt_rx_done <= 1'b0;
			num_processed <= '0;
			outpkt_type <= crack_pkg::RESULT;
			empty <= 1'b1;
			err <= 2'b00;
		end else begin
			pkt_rx_done <= 1'b0;
			din_vld <= (rd_left != 7'd0);
			if (rd_left != 7'd0)
				rd_left <= rd_left - 1'b1;

			// Comparison starts while the rest of the frame streams in
			cmp_start <= word_done && (word_cnt == 6'd5) && mode_cmp;

			// The answer is a pulse, keep it for the compare wait
			if (cmp_start) begin
				cmp_done <= 1'b0;
				cmp_hit <= 1'b0;
			end else if (cmp_found) begin
				cmp_done <= 1'b1;
				cmp_hit <= 1'b1;
				hit_num <= cmp_hash_num;
			end else if (cmp_finished) begin
				cmp_done <= 1'b1;
			end

			case (state)
				ST_DELAY: begin
					delay_cnt <= delay_cnt + 1'b1;
					if (delay_cnt == 6'd63)
						state <= ST_WAIT;
				end

				ST_WAIT: begin
					if (!unit_empty[unit_num]) begin
						rd_left <= 7'(FRAME_ITEMS);
						rd_count <= '0;
						word_cnt <= '0;
						state <= ST_RX_HEADER;
					end else begin
						unit_num <= unit_next;
					end
				end

				ST_RX_HEADER: begin
					if (din_vld) begin
						if (din == {W{1'b1}}) begin
							state <= ST_RX_DATA;
						end else begin
							err[0] <= 1'b1;
							state <= ST_HALT;
						end
					end
				end

				ST_RX_DATA: begin
					if (din_vld) begin
						if (rd_count == ITEMS_PER_WORD - 1) begin
							rd_count <= '0;
							word_cnt <= word_cnt + 1'b1;
							// Word 1 carries the packet ID
							if (word_cnt == 6'd1)
								pkt_id <= word_next;
							if (word_cnt == `RESULT_WORDS - 1)
								state <= ST_RX_END;
						end else begin
							rd_count <= rd_count + 1'b1;
						end
					end
				end

				ST_RX_END: begin
					if (din_vld) begin
						if (din != {W{1'b0}}) begin
							err[1] <= 1'b1;
							state <= ST_HALT;
						end else if (mode_cmp) begin
							state <= ST_CMP;
						end else begin
							outpkt_type <= crack_pkg::RESULT;
							empty <= 1'b0;
							state <= ST_OUT_RESULT;
						end
					end
				end

				ST_CMP: begin
					if (cmp_done) begin
						if (cmp_hit) begin
							outpkt_type <= crack_pkg::CMP_RESULT;
							hash_num <= hit_num;
							empty <= 1'b0;
							state <= ST_OUT_RESULT;
						end else begin
							state <= ST_PKT_ACCOUNT;
						end
					end
				end

				ST_OUT_RESULT: begin
					if (rd_en) begin
						empty <= 1'b1;
						state <= ST_PKT_ACCOUNT;
					end
				end

				ST_PKT_ACCOUNT: begin
					num_processed <= num_processed + 1'b1;
					unit_num <= unit_next;
					if (pkt_tx_done && num_processed_tx == num_processed + 32'd1) begin
						outpkt_type <= crack_pkg::PACKET_DONE;
						pkt_id <= pkt_id_tx;
						empty <= 1'b0;
						pkt_rx_done <= 1'b1;
						state <= ST_OUT_DONE;
					end else begin
						state <= ST_WAIT;
					end
				end

				ST_OUT_DONE: begin
					if (rd_en) begin
						empty <= 1'b1;
						num_processed <= '0;
						state <= ST_WAIT;
					end
				end

				// Frame errors park here until reset
				default: state <= ST_HALT;
			endcase
		end
	end

	a_one_cmp_per_frame: assert property (
		@(posedge CLK) disable iff (!rst_n)
		cmp_start |=> (!cmp_start until (state == ST_RX_END))
	);

endmodule

/* hash_comparator.sv */
`timescale 1ns/1ps
`include "crack_settings.svh"

module hash_comparator (
	input  logic CLK,
	input  logic rst_n,
	input  logic cmp_wr,
	input  logic [`HASH_NUM_W-1:0] cmp_addr,
	input  logic [31:0] cmp_value,
	input  logic cmp_start,
	input  logic [31:0] cmp_data,
	output logic cmp_found,
	output logic cmp_finished,
	output logic [`HASH_NUM_W-1:0] cmp_hash_num
);
	logic [31:0] targets [`CMP_DEPTH];
	logic [`CMP_DEPTH-1:0] valid;
	logic [31:0] key_r;
	logic [`HASH_NUM_W-1:0] idx;
	logic active;

	// Target values, only meaningful where valid is set
	always_ff @(posedge CLK) begin
		if (cmp_wr)
			targets[cmp_addr] <= cmp_value;
		if (cmp_start)
			key_r <= cmp_data;
	end

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			valid <= '0;
			idx <= '0;
			active <= 1'b0;
			cmp_found <= 1'b0;
			cmp_finished <= 1'b0;
			cmp_hash_num <= '0;
		end else begin
			cmp_found <= 1'b0;
			cmp_finished <= 1'b0;

			if (cmp_wr)
				valid[cmp_addr] <= 1'b1;

			if (cmp_start) begin
				idx <= '0;
				active <= 1'b1;
			end else if (active) begin
				// One entry per cycle from index 0, first match wins
				if (valid[idx] && targets[idx] == key_r) begin
					cmp_found <= 1'b1;
					cmp_hash_num <= idx;
					active <= 1'b0;
				end else if (idx == `CMP_DEPTH - 1) begin
					cmp_finished <= 1'b1;
					active <= 1'b0;
				end else begin
					idx <= idx + 1'b1;
				end
			end
		end
	end

endmodule

/* crack_top.sv */
`timescale 1ns/1ps
`include "crack_settings.svh"

module crack_top (
	input  logic CLK,
	input  logic rst_n,
	input  logic mode_cmp,
	input  logic pkt_start,
	input  logic [15:0] pkt_id_in,
	input  logic [31:0] pkt_len,
	input  logic job_wr,
	input  crack_pkg::job_t job,
	output logic job_full,
	input  logic cmp_wr,
	input  logic [`HASH_NUM_W-1:0] cmp_addr,
	input  logic [31:0] cmp_value,
	output crack_pkg::outpkt_type_e outpkt_type,
	output logic [15:0] dout,
	input  logic [5:0] rd_addr,
	output logic [15:0] pkt_id,
	output logic [31:0] num_processed,
	output logic [`HASH_NUM_W-1:0] hash_num,
	input  logic rd_en,
	output logic empty,
	output logic [1:0] err
);
	localparam int W = `UNIT_OUTPUT_WIDTH;

	logic [`N_UNITS-1:0] unit_start;
	logic [`N_UNITS-1:0] unit_busy;
	logic [`N_UNITS-1:0] unit_empty;
	logic [`N_UNITS-1:0] unit_rd_en;
	logic [`N_UNITS*W-1:0] unit_dout;
	crack_pkg::job_t unit_job;
	logic [15:0] unit_pkt_id;
	logic [31:0] num_processed_tx;
	logic [15:0] pkt_id_tx;
	logic pkt_tx_done;
	logic pkt_rx_done;
	logic [31:0] cmp_data;
	logic cmp_start;
	logic cmp_found;
	logic cmp_finished;
	logic [`HASH_NUM_W-1:0] cmp_hash_num;

	job_dispatcher i_dispatcher (
		.CLK(CLK),
		.rst_n(rst_n),
		.pkt_start(pkt_start),
		.pkt_id_in(pkt_id_in),
		.pkt_len(pkt_len),
		.job_wr(job_wr),
		.job(job),
		.unit_busy(unit_busy),
		.pkt_rx_done(pkt_rx_done),
		.job_full(job_full),
		.unit_start(unit_start),
		.unit_job(unit_job),
		.unit_pkt_id(unit_pkt_id),
		.num_processed_tx(num_processed_tx),
		.pkt_id_tx(pkt_id_tx),
		.pkt_tx_done(pkt_tx_done)
	);

	// Units share the job bus, each has its own start and output slice
	for (genvar i = 0; i < `N_UNITS; i++) begin : g_unit
		hash_unit i_unit (
			.CLK(CLK),
			.rst_n(rst_n),
			.start(unit_start[i]),
			.job(unit_job),
			.pkt_id(unit_pkt_id),
			.rd_en(unit_rd_en[i]),
			.busy(unit_busy[i]),
			.dout(unit_dout[i*W +: W]),
			.empty(unit_empty[i])
		);
	end

	result_collector i_collector (
		.CLK(CLK),
		.rst_n(rst_n),
		.mode_cmp(mode_cmp),
		.unit_dout(unit_dout),
		.unit_empty(unit_empty),
		.unit_rd_en(unit_rd_en),
		.num_processed_tx(num_processed_tx),
		.pkt_id_tx(pkt_id_tx),
		.pkt_tx_done(pkt_tx_done),
		.pkt_rx_done(pkt_rx_done),
		.cmp_data(cmp_data),
		.cmp_start(cmp_start),
		.cmp_found(cmp_found),
		.cmp_finished(cmp_finished),
		.cmp_hash_num(cmp_hash_num),
		.outpkt_type(outpkt_type),
		.dout(dout),
		.rd_addr(rd_addr),
		.pkt_id(pkt_id),
		.num_processed(num_processed),
		.hash_num(hash_num),
		.rd_en(rd_en),
		.empty(empty),
		.err(err)
	);

	hash_comparator i_comparator (
		.CLK(CLK),
		.rst_n(rst_n),
		.cmp_wr(cmp_wr),
		.cmp_addr(cmp_addr),
		.cmp_value(cmp_value),
		.cmp_start(cmp_start),
		.cmp_data(cmp_data),
		.cmp_found(cmp_found),
		.cmp_finished(cmp_finished),
		.cmp_hash_num(cmp_hash_num)
	);

endmodule

/* tb_crack.sv */
`timescale 1ns/1ps
`include "crack_settings.svh"

module tb_crack;
	localparam int WAIT_LIMIT = 3000;

	// Expected result of one job
	typedef struct packed {
		crack_pkg::unit_ids_t ids;
		logic [`HASH_NUM_W-1:0] hash;
	} exp_t;

	logic CLK = 1'b0;
	logic rst_n;
	logic mode_cmp;
	logic pkt_start;
	logic [15:0] pkt_id_in;
	logic [31:0] pkt_len;
	logic job_wr;
	crack_pkg::job_t job;
	logic job_full;
	logic cmp_wr;
	logic [`HASH_NUM_W-1:0] cmp_addr;
	logic [31:0] cmp_value;
	crack_pkg::outpkt_type_e outpkt_type;
	logic [15:0] dout;
	logic [5:0] rd_addr;
	logic [15:0] pkt_id;
	logic [31:0] num_processed;
	logic [`HASH_NUM_W-1:0] hash_num;
	logic rd_en;
	logic empty;
	logic [1:0] err;

	integer seed = 48978;
	int val_errs = 0;
	int other_errs = 0;
	logic [15:0] job_seq = 16'h0;
	logic [31:0] tgt [`CMP_DEPTH];
	logic [`CMP_DEPTH-1:0] tgt_valid = '0;
	crack_pkg::job_t pend_q[$];
	exp_t exp_q[$];

	crack_top i_dut (
		.CLK(CLK),
		.rst_n(rst_n),
		.mode_cmp(mode_cmp),
		.pkt_start(pkt_start),
		.pkt_id_in(pkt_id_in),
		.pkt_len(pkt_len),
		.job_wr(job_wr),
		.job(job),
		.job_full(job_full),
		.cmp_wr(cmp_wr),
		.cmp_addr(cmp_addr),
		.cmp_value(cmp_value),
		.outpkt_type(outpkt_type),
		.dout(dout),
		.rd_addr(rd_addr),
		.pkt_id(pkt_id),
		.num_processed(num_processed),
		.hash_num(hash_num),
		.rd_en(rd_en),
		.empty(empty),
		.err(err)
	);

	always #4 CLK = ~CLK;

	// Digest word n of a job after n+1 rounds of rotate, XOR and add key
	function automatic logic [63:0] model_digest(input logic [31:0] key,
			input logic [15:0] wid, input int n);
		logic [63:0] x;
		int i;
		x = {key, 16'h0, wid};
		for (i = 0; i <= n; i++) begin
			x = {x[50:0], x[63:51]} ^ 64'h9E37_79B9_7F4A_7C15;
			x = x + {32'h0, key};
		end
		return x;
	endfunction

	// Lowest table index holding v or -1 when no valid target does
	function automatic int match_index(input logic [31:0] v);
		int a;
		int hit;
		hit = -1;
		for (a = `CMP_DEPTH - 1; a >= 0; a--) begin
			if (tgt_valid[a] && tgt[a] == v)
				hit = a;
		end
		return hit;
	endfunction

	task automatic check_type(input string name, input crack_pkg::outpkt_type_e exp,
			input crack_pkg::outpkt_type_e act);
		if (act !== exp) begin
			$display("ERR t=%0t %s: expected %0d, got %0d", $time, name, exp, act);
			val_errs++;
		end
	endtask

	task automatic check_ids(input string name, input crack_pkg::unit_ids_t exp,
			input crack_pkg::unit_ids_t act);
		if (act !== exp) begin
			$display("ERR t=%0t %s: expected %h, got %h", $time, name, exp, act);
			val_errs++;
		end
	endtask

	task automatic check_digest(input string name, input logic [63:0] exp,
			input logic [63:0] act);
		if (act !== exp) begin
			$display("ERR t=%0t %s: expected %h, got %h", $time, name, exp, act);
			val_errs++;
		end
	endtask

	task automatic check_count16(input string name, input logic [15:0] exp,
			input logic [15:0] act);
		if (act !== exp) begin
			$display("ERR t=%0t %s: expected %h, got %h", $time, name, exp, act);
			val_errs++;
		end
	endtask

	task automatic check_count32(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		if (act !== exp) begin
			$display("ERR t=%0t %s: expected %0d, got %0d", $time, name, exp, act);
			val_errs++;
		end
	endtask

	task automatic check_hash(input string name, input logic [`HASH_NUM_W-1:0] exp,
			input logic [`HASH_NUM_W-1:0] act);
		if (act !== exp) begin
			$display("ERR t=%0t %s: expected %0d, got %0d", $time, name, exp, act);
			val_errs++;
		end
	endtask

	task automatic check_err(input string name, input logic [1:0] exp, input logic [1:0] act);
		if (act !== exp) begin
			$display("ERR t=%0t %s: expected %b, got %b", $time, name, exp, act);
			val_errs++;
		end
	endtask

	task automatic check_level(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("ERR t=%0t %s: expected %b, got %b", $time, name, exp, act);
			val_errs++;
		end
	endtask

	task automatic end_run();
		$display("Errors: %0d value mismatches, %0d other failures", val_errs, other_errs);
		if (val_errs == 0 && other_errs == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	endtask

	task automatic abort_run(input string reason);
		$display("%0t: %s", $time, reason);
		other_errs++;
		$display("Errors: %0d value mismatches, %0d other failures", val_errs, other_errs);
		$display("Verification failed");
		$finish;
	endtask

	task automatic gen_jobs(input int len);
		crack_pkg::job_t j;
		int i;
		for (i = 0; i < len; i++) begin
			j.key = $random(seed);
			j.word_id = job_seq;
			job_seq++;
			pend_q.push_back(j);
		end
	endtask

	task automatic write_targets();
		logic [31:0] r;
		logic [63:0] d;
		crack_pkg::job_t j;
		int a;
		for (a = 0; a < `CMP_DEPTH; a++) begin
			r = $random(seed);
			// About half of the targets hit a coming job
			if (r[0]) begin
				j = pend_q[r[15:8] % pend_q.size()];
				d = model_digest(j.key, j.word_id, 0);
				tgt[a] = d[31:0];
			end else begin
				tgt[a] = $random(seed);
			end
			tgt_valid[a] = 1'b1;
			cmp_wr = 1'b1;
			cmp_addr = a[`HASH_NUM_W-1:0];
			cmp_value = tgt[a];
			@(posedge CLK);
			#1;
		end
		cmp_wr = 1'b0;
	endtask

	task automatic send_jobs(input logic [15:0] pid, input logic [31:0] len);
		crack_pkg::job_t j;
		exp_t e;
		logic [63:0] d;
		int hit;
		int n;
		pkt_start = 1'b1;
		pkt_id_in = pid;
		pkt_len = len;
		@(posedge CLK);
		#1;
		pkt_start = 1'b0;
		while (pend_q.size() > 0) begin
			n = 0;
			while (job_full !== 1'b0) begin
				@(posedge CLK);
				#1;
				n++;
				if (n > WAIT_LIMIT)
					abort_run("job_full never dropped, no unit became idle");
			end
			j = pend_q.pop_front();
			e.ids.word_id = j.word_id;
			e.ids.pkt_id = pid;
			e.ids.key_lo = j.key[15:0];
			e.ids.key_hi = j.key[31:16];
			d = model_digest(j.key, j.word_id, 0);
			hit = match_index(d[31:0]);
			e.hash = (hit < 0) ? '0 : hit[`HASH_NUM_W-1:0];
			// Compare mode only reports jobs that hit a target
			if (!mode_cmp || hit >= 0)
				exp_q.push_back(e);
			job = j;
			job_wr = 1'b1;
			@(posedge CLK);
			#1;
			job_wr = 1'b0;
		end
	endtask

	task automatic wait_output();
		int n;
		n = 0;
		while (empty !== 1'b0) begin
			@(posedge CLK);
			#1;
			n++;
			if (n > WAIT_LIMIT)
				abort_run("no output packet appeared, empty stayed high");
		end
	endtask

	task automatic take_result();
		logic [15:0] w [`RESULT_WORDS];
		crack_pkg::unit_ids_t ids;
		exp_t e;
		int i;
		int k;
		int found;
		for (i = 0; i < `RESULT_WORDS; i++) begin
			rd_addr = i[5:0];
			#1;
			w[i] = dout;
			@(posedge CLK);
			#1;
		end
		ids = {w[3], w[2], w[1], w[0]};
		found = -1;
		for (i = 0; i < exp_q.size(); i++) begin
			if (found < 0 && exp_q[i].ids.word_id == ids.word_id)
				found = i;
		end
		if (found < 0) begin
			$display("%0t: result for word_id %h was not expected or came twice",
				$time, ids.word_id);
			other_errs++;
		end else begin
			e = exp_q[found];
			exp_q.delete(found);
			check_ids("dout words 0-3", e.ids, ids);
			check_count16("pkt_id", e.ids.pkt_id, pkt_id);
			for (k = 0; k < 8; k++) begin
				check_digest($sformatf("digest word %0d", k),
					model_digest({e.ids.key_hi, e.ids.key_lo}, e.ids.word_id, k),
					{w[4*k+7], w[4*k+6], w[4*k+5], w[4*k+4]});
			end
			if (mode_cmp)
				check_hash("hash_num", e.hash, hash_num);
		end
	endtask

	task automatic read_packets(input logic [15:0] pid, input logic [31:0] len);
		crack_pkg::outpkt_type_e res_type;
		logic done;
		done = 1'b0;
		res_type = mode_cmp ? crack_pkg::CMP_RESULT : crack_pkg::RESULT;
		while (!done) begin
			wait_output();
			if (outpkt_type === crack_pkg::PACKET_DONE) begin
				check_count16("pkt_id", pid, pkt_id);
				check_count32("num_processed", len, num_processed);
				if (exp_q.size() != 0) begin
					$display("%0t: %0d results of packet %h never arrived",
						$time, exp_q.size(), pid);
					other_errs += exp_q.size();
					exp_q.delete();
				end
				done = 1'b1;
			end else begin
				check_type("outpkt_type", res_type, outpkt_type);
				take_result();
			end
			check_err("err", 2'b00, err);
			// One strobe hands the packet back
			rd_en = 1'b1;
			@(posedge CLK);
			#1;
			rd_en = 1'b0;
		end
	endtask

	task automatic run_packet(input logic [15:0] pid, input logic [31:0] len, input int stall);
		fork
			send_jobs(pid, len);
			begin
				if (stall > 0) begin
					repeat (stall) @(posedge CLK);
					#1;
					check_level("job_full", 1'b1, job_full);
				end
				read_packets(pid, len);
			end
		join
	endtask

	initial begin
		logic [31:0] r;
		logic [15:0] pid;
		logic [31:0] len;
		int p;
		rst_n = 1'b0;
		mode_cmp = 1'b0;
		pkt_start = 1'b0;
		pkt_id_in = '0;
		pkt_len = '0;
		job_wr = 1'b0;
		job = '0;
		cmp_wr = 1'b0;
		cmp_addr = '0;
		cmp_value = '0;
		rd_addr = '0;
		rd_en = 1'b0;
		repeat (3) @(posedge CLK);
		#1;
		rst_n = 1'b1;
		check_level("empty", 1'b1, empty);
		check_level("job_full", 1'b1, job_full);
		check_err("err", 2'b00, err);

		// Normal mode with short packets of random length
		for (p = 0; p < 3; p++) begin
			r = $random(seed);
			pid = r[31:16];
			len = 32'd1 + r[2:0];
			gen_jobs(len);
			run_packet(pid, len, 0);
		end

		// Host holds the output long enough for all units to fill
		r = $random(seed);
		gen_jobs(10);
		run_packet(r[15:0], 32'd10, 300);

		// Compare mode with fresh targets per packet
		mode_cmp = 1'b1;
		for (p = 0; p < 2; p++) begin
			r = $random(seed);
			gen_jobs(8);
			write_targets();
			run_packet(r[15:0], 32'd8, 0);
		end

		check_err("err", 2'b00, err);
		end_run();
	end

endmodule

/* compile.f */
+incdir+.
crack_pkg.sv
job_dispatcher.sv
hash_unit.sv
result_collector.sv
hash_comparator.sv
crack_top.sv
tb_crack.sv
